//--- csrMerge.sv
`timescale 1ns/1ns

// CSR shadow state
// Merges the RVFI masked read and write values into the
// architectural value and flags every CSR that changed
module csrMerge (
  input  logic                                                           rvvi,
  input  logic                                                           rstN,
  input  logic                                                           retireValid,
  // Per slot RVFI CSR fields
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0]          csrRdata,
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0]          csrRmask,
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0]          csrWdata,
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0]          csrWmask,
  // Architectural view
  output logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0]          csrValue,
  output logic [rvviCsrPkg::numCsrs-1:0]                                 csrWb
);

  // Merged value of the retirement currently strobed
  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] mergedValue;

  // Slots whose merged value differs from the shadow
  logic [rvviCsrPkg::numCsrs-1:0] valueChanged;

  //////////////////////////////
  // Mask merge
  //////////////////////////////

  // Written bits come from wdata, all other bits keep rdata
  // csrRmask only says which bits were read and does not
  // take part in the merge, it stays on the port for the RVFI format
  always_comb begin
    for (int slot = 0; slot < rvviCsrPkg::numCsrs; slot++) begin
      mergedValue[slot] = (csrWdata[slot] & csrWmask[slot])
                        | (csrRdata[slot] & ~csrWmask[slot]);
    end
  end

  //////////////////////////////
  // Change detect
  //////////////////////////////

  // Compare against the shadow before it is overwritten
  always_comb begin
    for (int slot = 0; slot < rvviCsrPkg::numCsrs; slot++) begin
      valueChanged[slot] = (mergedValue[slot] != csrValue[slot]);
    end
  end

  //////////////////////////////
  // Shadow registers
  //////////////////////////////

  // Shadow holds between retirements
  // Reset loads the architectural reset value of each CSR
  always_ff @(posedge rvvi) begin
    if (!rstN) begin
      csrValue <= rvviCsrPkg::csrResetTable;
    end else if (retireValid) begin
      csrValue <= mergedValue;
    end
  end

  // Writeback flags pulse for one cycle alongside rvviValid
  // Identical retirements leave the flags low
  always_ff @(posedge rvvi) begin
    if (!rstN) begin
      csrWb <= '0;
    end else if (retireValid) begin
      csrWb <= valueChanged;
    end else begin
      csrWb <= '0;
    end
  end

endmodule

//--- gprWriteback.sv
`timescale 1ns/1ns

// Destination register writeback
// Turns the single RVFI rd write into a one-hot RVVI mask
module gprWriteback (
  input  logic                                  rvvi,
  input  logic                                  rstN,
  input  logic                                  retireValid,
  input  logic                                  trap,
  // RVFI destination write
  input  logic [rvviTracePkg::regAddrWidth-1:0] rdAddr,
  input  logic [rvviTracePkg::xlen-1:0]         rdWdata,
  // RVVI writeback
  output logic [rvviTracePkg::numGprs-1:0]      gprWb,
  output logic [rvviTracePkg::xlen-1:0]         gprWdata
);

  // One-hot decode of rdAddr, bit 0 never set
  logic [rvviTracePkg::numGprs-1:0] rdOneHot;

  // x0 is hardwired and a trapped instruction writes nothing
  logic writeEnable;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign writeEnable = retireValid && !trap && (rdAddr != '0);

  always_comb begin
    rdOneHot = '0;
    for (int reg_i = 1; reg_i < rvviTracePkg::numGprs; reg_i++) begin
      rdOneHot[reg_i] = (rdAddr == rvviTracePkg::regAddrWidth'(reg_i));
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  // Mask lives for one cycle only
  always_ff @(posedge rvvi) begin
    if (!rstN) begin
      gprWb <= '0;
    end else if (writeEnable) begin
      gprWb <= rdOneHot;
    end else begin
      gprWb <= '0;
    end
  end

  // Data word follows every strobe, meaningful only with gprWb
  always_ff @(posedge rvvi) begin
    if (retireValid) begin
      gprWdata <= rdWdata;
    end
  end

endmodule

//--- retireStage.sv
`timescale 1ns/1ns

// Retirement record register
// One strobe in, one valid pulse out on the next edge
module retireStage (
  input  logic                                  rvvi,
  input  logic                                  rstN,
  // RVFI retirement record
  input  logic                                  retireValid,
  input  logic [rvviTracePkg::orderWidth-1:0]   order,
  input  logic [rvviTracePkg::insnWidth-1:0]    insn,
  input  logic                                  trap,
  input  logic                                  intr,
  input  rvviTracePkg::privMode_t               mode,
  input  logic [rvviTracePkg::xlen-1:0]         pcRdata,
  // RVVI side
  output logic                                  rvviValid,
  output logic [rvviTracePkg::orderWidth-1:0]   rvviOrder,
  output logic [rvviTracePkg::insnWidth-1:0]    rvviInsn,
  output logic                                  rvviTrap,
  output logic                                  rvviIntr,
  output rvviTracePkg::privMode_t               rvviMode,
  output logic [rvviTracePkg::xlen-1:0]         rvviPc
);

  //////////////////////////////
  // Valid strobe
  //////////////////////////////

  // Valid follows the strobe with one cycle of latency
  // Back to back strobes give a valid that stays high
  always_ff @(posedge rvvi) begin
    if (!rstN) begin
      rvviValid <= 1'b0;
    end else begin
      rvviValid <= retireValid;
    end
  end

  //////////////////////////////
  // Record capture
  //////////////////////////////

  // Fields only load on a strobe and hold until the next one
  // so the checker side may sample them in any cycle
  always_ff @(posedge rvvi) begin
    if (!rstN) begin
      rvviOrder <= '0;
      rvviInsn  <= '0;
      rvviTrap  <= 1'b0;
      rvviIntr  <= 1'b0;
      // Core comes out of reset in machine mode
      rvviMode  <= rvviTracePkg::machineMode;
      rvviPc    <= '0;
    end else if (retireValid) begin
      rvviOrder <= order;
      rvviInsn  <= insn;
      rvviTrap  <= trap;
      rvviIntr  <= intr;
      rvviMode  <= mode;
      rvviPc    <= pcRdata;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the RVFI to RVVI adapter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tbRvfiToRvvi -f rvfiToRvvi.f -o simRvfiToRvvi

./obj_dir/simRvfiToRvvi > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
  exit 1
fi
grep -qF "*** PASSED ***" sim.log

//--- rvfiToRvvi.f
rvviTracePkg.sv
rvviCsrPkg.sv
retireStage.sv
csrMerge.sv
gprWriteback.sv
rvfiToRvvi.sv
tbRvfiToRvvi.sv

//--- rvfiToRvvi.sv
`timescale 1ns/1ns

// RVFI to RVVI trace adapter
// Every output describes the retirement strobed one cycle earlier
module rvfiToRvvi (
  input  logic                                                  rvvi,
  input  logic                                                  rstN,
  // RVFI retirement
  input  logic                                                  retireValid,
  input  logic [rvviTracePkg::orderWidth-1:0]                   order,
  input  logic [rvviTracePkg::insnWidth-1:0]                    insn,
  input  logic                                                  trap,
  input  logic                                                  intr,
  input  rvviTracePkg::privMode_t                               mode,
  input  logic [rvviTracePkg::xlen-1:0]                         pcRdata,
  // RVFI destination write
  input  logic [rvviTracePkg::regAddrWidth-1:0]                 rdAddr,
  input  logic [rvviTracePkg::xlen-1:0]                         rdWdata,
  // RVFI CSR fields, one word per slot
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrRdata,
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrRmask,
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrWdata,
  input  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrWmask,
  // RVVI retirement state
  output logic                                                  rvviValid,
  output logic [rvviTracePkg::orderWidth-1:0]                   rvviOrder,
  output logic [rvviTracePkg::insnWidth-1:0]                    rvviInsn,
  output logic                                                  rvviTrap,
  output logic                                                  rvviIntr,
  output rvviTracePkg::privMode_t                               rvviMode,
  output logic [rvviTracePkg::xlen-1:0]                         rvviPc,
  // RVVI CSR state
  output logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrValue,
  output logic [rvviCsrPkg::numCsrs-1:0]                        csrWb,
  // RVVI integer writeback
  output logic [rvviTracePkg::numGprs-1:0]                      gprWb,
  output logic [rvviTracePkg::xlen-1:0]                         gprWdata
);

  //////////////////////////////
  // Retirement record
  //////////////////////////////

  retireStage i_retireStage (
    .rvvi        (rvvi),
    .rstN        (rstN),
    .retireValid (retireValid),
    .order       (order),
    .insn        (insn),
    .trap        (trap),
    .intr        (intr),
    .mode        (mode),
    .pcRdata     (pcRdata),
    .rvviValid   (rvviValid),
    .rvviOrder   (rvviOrder),
    .rvviInsn    (rvviInsn),
    .rvviTrap    (rvviTrap),
    .rvviIntr    (rvviIntr),
    .rvviMode    (rvviMode),
    .rvviPc      (rvviPc)
  );

  //////////////////////////////
  // CSR shadow
  //////////////////////////////

  csrMerge i_csrMerge (
    .rvvi        (rvvi),
    .rstN        (rstN),
    .retireValid (retireValid),
    .csrRdata    (csrRdata),
    .csrRmask    (csrRmask),
    .csrWdata    (csrWdata),
    .csrWmask    (csrWmask),
    .csrValue    (csrValue),
    .csrWb       (csrWb)
  );

  //////////////////////////////
  // GPR writeback
  //////////////////////////////

  // Trap squashes the register write
  gprWriteback i_gprWriteback (
    .rvvi        (rvvi),
    .rstN        (rstN),
    .retireValid (retireValid),
    .trap        (trap),
    .rdAddr      (rdAddr),
    .rdWdata     (rdWdata),
    .gprWb       (gprWb),
    .gprWdata    (gprWdata)
  );

endmodule

//--- rvviCsrPkg.sv
// Tracked machine mode CSRs and their fixed properties
package rvviCsrPkg;

  //////////////////////////////
  // Slots
  //////////////////////////////

  // Each tracked CSR owns one slot in the packed CSR arrays
  // Slot order follows the architectural address order
  typedef enum logic [2:0] {
    slotMstatus  = 3'd0,
    slotMisa     = 3'd1,
    slotMie      = 3'd2,
    slotMtvec    = 3'd3,
    slotMscratch = 3'd4,
    slotMepc     = 3'd5,
    slotMcause   = 3'd6,
    slotMip      = 3'd7
  } csrSlot_t;

  // Number of tracked CSRs, one per enum value
  localparam int numCsrs = 8;

  //////////////////////////////
  // Address table
  //////////////////////////////

  // Architectural 12-bit CSR address per slot
  // Listed from the highest slot down to slot 0
  localparam logic [numCsrs-1:0][11:0] csrAddrTable = {
    12'h344,  // mip
    12'h342,  // mcause
    12'h341,  // mepc
    12'h340,  // mscratch
    12'h305,  // mtvec
    12'h304,  // mie
    12'h301,  // misa
    12'h300   // mstatus
  };

  //////////////////////////////
  // Reset values
  //////////////////////////////

  // Value each CSR holds out of reset, highest slot first
  // misa reports MXL=1 with the I, M and C extensions
  localparam logic [numCsrs-1:0][rvviTracePkg::xlen-1:0] csrResetTable = {
    32'h0000_0000,  // mip
    32'h0000_0000,  // mcause
    32'h0000_0000,  // mepc
    32'h0000_0000,  // mscratch
    32'h0000_0000,  // mtvec
    32'h0000_0000,  // mie
    32'h4000_1104,  // misa
    32'h0000_0000   // mstatus
  };

endpackage

//--- rvviTracePkg.sv
// Trace widths and architectural sizes shared by every stage
package rvviTracePkg;

  //////////////////////////////
  // Data path widths
  //////////////////////////////

  // Register and address width of the RV32 core
  localparam int xlen = 32;

  // Instruction word as reported by RVFI, compressed forms zero extended
  localparam int insnWidth = 32;

  // Retirement order counter, wide enough never to wrap in a run
  localparam int orderWidth = 64;

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Integer register file, x0 included
  localparam int numGprs = 32;

  // Index width of a destination register
  localparam int regAddrWidth = 5;

  //////////////////////////////
  // Privilege
  //////////////////////////////

  // RISC-V privilege encoding
  // Value 2 is reserved and never reported by the core
  typedef enum logic [1:0] {
    userMode       = 2'd0,
    supervisorMode = 2'd1,
    machineMode    = 2'd3
  } privMode_t;

endpackage

//--- tbRvfiToRvvi.sv
`timescale 1ns/1ns

module tbRvfiToRvvi;

  // Clock period in ns
  localparam int clkPeriod = 40;
  // Edge budget of the whole stimulus including reset
  localparam int stimCycles = 76;

  // One captured retirement as the DUT saw it on an edge
  typedef struct packed {
    logic                                                  rst;
    logic                                                  valid;
    logic [rvviTracePkg::orderWidth-1:0]                   order;
    logic [rvviTracePkg::insnWidth-1:0]                    insn;
    logic                                                  trap;
    logic                                                  intr;
    rvviTracePkg::privMode_t                               mode;
    logic [rvviTracePkg::xlen-1:0]                         pc;
    logic [rvviTracePkg::regAddrWidth-1:0]                 rdAddr;
    logic [rvviTracePkg::xlen-1:0]                         rdWdata;
    logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] rdata;
    logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] wdata;
    logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] wmask;
  } retireRec_t;

  logic rvvi = 1'b0;
  logic rstN;
  logic retireValid;
  logic [rvviTracePkg::orderWidth-1:0] order;
  logic [rvviTracePkg::insnWidth-1:0] insn;
  logic trap;
  logic intr;
  rvviTracePkg::privMode_t mode;
  logic [rvviTracePkg::xlen-1:0] pcRdata;
  logic [rvviTracePkg::regAddrWidth-1:0] rdAddr;
  logic [rvviTracePkg::xlen-1:0] rdWdata;
  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrRdata;
  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrRmask;
  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrWdata;
  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrWmask;

  logic rvviValid;
  logic [rvviTracePkg::orderWidth-1:0] rvviOrder;
  logic [rvviTracePkg::insnWidth-1:0] rvviInsn;
  logic rvviTrap;
  logic rvviIntr;
  rvviTracePkg::privMode_t rvviMode;
  logic [rvviTracePkg::xlen-1:0] rvviPc;
  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] csrValue;
  logic [rvviCsrPkg::numCsrs-1:0] csrWb;
  logic [rvviTracePkg::numGprs-1:0] gprWb;
  logic [rvviTracePkg::xlen-1:0] gprWdata;

  int seed = 14617;
  int strobeCount = 0;
  int validCount = 0;
  logic [rvviTracePkg::orderWidth-1:0] nextOrder = 64'd1;
  logic [rvviTracePkg::orderWidth-1:0] expOrder = 64'd1;

  // Reference state, updated one retirement at a time
  retireRec_t stimQ[$];
  retireRec_t held;
  logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] shadow;

  rvfiToRvvi i_rvfiToRvvi (.*);

  always #(clkPeriod / 2) rvvi = ~rvvi;

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic failRun();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic checkValue(input string name, input logic [63:0] expVal,
                            input logic [63:0] actVal);
    assert (actVal === expVal) else begin
      $display("** Error at %0t ns: %s expected %h actual %h", $time, name, expVal, actVal);
      failRun();
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // New random record without the strobe
  // maskKind 0 random masks, 1 all-zero, 2 all-ones
  task automatic randomizeRecord(input int maskKind);
    logic [31:0] rnd;
    rnd = $random(seed);
    insn <= $random(seed);
    pcRdata <= $random(seed);
    rdWdata <= $random(seed);
    rdAddr <= rnd[4:0];
    trap <= (rnd[11:8] == 4'd0);
    intr <= (rnd[15:12] == 4'd0);
    case (rnd[17:16])
      2'd0: mode <= rvviTracePkg::userMode;
      2'd1: mode <= rvviTracePkg::supervisorMode;
      default: mode <= rvviTracePkg::machineMode;
    endcase
    for (int slot = 0; slot < rvviCsrPkg::numCsrs; slot++) begin
      rnd = $random(seed);
      // Some slots keep last fields so their merge repeats
      if (maskKind != 0 || rnd[1:0] != 2'd0) begin
        csrRdata[slot] <= $random(seed);
        csrRmask[slot] <= $random(seed);
        csrWdata[slot] <= $random(seed);
        if (maskKind == 1) csrWmask[slot] <= '0;
        else if (maskKind == 2) csrWmask[slot] <= '1;
        else csrWmask[slot] <= $random(seed);
      end
    end
  endtask

  task automatic strobeRetire(input int maskKind, input bit forceTrap, input bit forceX0);
    @(posedge rvvi);
    randomizeRecord(maskKind);
    if (forceTrap) trap <= 1'b1;
    if (forceX0) rdAddr <= '0;
    retireValid <= 1'b1;
    order <= nextOrder;
    nextOrder = nextOrder + 64'd1;
    strobeCount++;
  endtask

  // Same fields as the strobe just before with a new order number
  task automatic repeatRetire();
    @(posedge rvvi);
    retireValid <= 1'b1;
    order <= nextOrder;
    nextOrder = nextOrder + 64'd1;
    strobeCount++;
  endtask

  // Fields keep changing while no strobe is given
  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge rvvi);
      retireValid <= 1'b0;
      randomizeRecord(0);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Inputs as sampled by the DUT on this edge
  always @(posedge rvvi) begin
    retireRec_t rec;
    rec = '{rst: rstN, valid: retireValid, order: order, insn: insn, trap: trap,
            intr: intr, mode: mode, pc: pcRdata, rdAddr: rdAddr, rdWdata: rdWdata,
            rdata: csrRdata, wdata: csrWdata, wmask: csrWmask};
    stimQ.push_back(rec);
  end

  // Outputs are stable mid cycle
  always @(negedge rvvi) begin
    retireRec_t rec;
    logic [rvviCsrPkg::numCsrs-1:0][rvviTracePkg::xlen-1:0] merged;
    logic [rvviCsrPkg::numCsrs-1:0] expCsrWb;
    logic [rvviTracePkg::numGprs-1:0] expGprWb;
    if (stimQ.size() != 0) begin
      rec = stimQ.pop_front();
      expCsrWb = '0;
      expGprWb = '0;
      if (!rec.rst) begin
        shadow = rvviCsrPkg::csrResetTable;
        held = '0;
        held.mode = rvviTracePkg::machineMode;
      end else if (rec.valid) begin
        for (int slot = 0; slot < rvviCsrPkg::numCsrs; slot++) begin
          merged[slot] = (rec.wdata[slot] & rec.wmask[slot])
                       | (rec.rdata[slot] & ~rec.wmask[slot]);
          expCsrWb[slot] = (merged[slot] != shadow[slot]);
        end
        shadow = merged;
        held = rec;
        // x0 and trapped instructions never write
        if (!rec.trap && rec.rdAddr != '0) expGprWb[rec.rdAddr] = 1'b1;
        checkValue("gprWdata", 64'(rec.rdWdata), 64'(gprWdata));
        checkValue("rvviOrder sequence", expOrder, rvviOrder);
        expOrder = expOrder + 64'd1;
      end
      checkValue("rvviValid", 64'(rec.rst && rec.valid), 64'(rvviValid));
      checkValue("rvviOrder", held.order, rvviOrder);
      checkValue("rvviInsn", 64'(held.insn), 64'(rvviInsn));
      checkValue("rvviTrap", 64'(held.trap), 64'(rvviTrap));
      checkValue("rvviIntr", 64'(held.intr), 64'(rvviIntr));
      checkValue("rvviMode", 64'(held.mode), 64'(rvviMode));
      checkValue("rvviPc", 64'(held.pc), 64'(rvviPc));
      for (int slot = 0; slot < rvviCsrPkg::numCsrs; slot++) begin
        checkValue($sformatf("csrValue[%03h]", rvviCsrPkg::csrAddrTable[slot]),
                   64'(shadow[slot]), 64'(csrValue[slot]));
      end
      checkValue("csrWb", 64'(expCsrWb), 64'(csrWb));
      checkValue("gprWb", 64'(expGprWb), 64'(gprWb));
      // Pulses seen on the DUT side
      if (rvviValid === 1'b1) validCount++;
    end
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    #((stimCycles + 20) * clkPeriod);
    $display("Watchdog timeout, stimulus did not finish in time");
    failRun();
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rstN = 1'b0;
    retireValid = 1'b0;
    order = '0;
    insn = '0;
    trap = 1'b0;
    intr = 1'b0;
    mode = rvviTracePkg::machineMode;
    pcRdata = '0;
    rdAddr = '0;
    rdWdata = '0;
    csrRdata = '0;
    csrRmask = '0;
    csrWdata = '0;
    csrWmask = '0;
    repeat (8) @(posedge rvvi);
    rstN <= 1'b1;
    // Directed retirements
    strobeRetire(0, 1'b0, 1'b0);
    strobeRetire(0, 1'b0, 1'b0);
    strobeRetire(0, 1'b0, 1'b0);
    repeatRetire();
    repeatRetire();
    idleCycles(3);
    strobeRetire(1, 1'b0, 1'b0);
    strobeRetire(2, 1'b0, 1'b0);
    strobeRetire(0, 1'b1, 1'b0);
    strobeRetire(0, 1'b0, 1'b1);
    idleCycles(2);
    // Back to back burst
    repeat (50) strobeRetire(0, 1'b0, 1'b0);
    idleCycles(4);
    if (validCount == strobeCount) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Retirements lost, %0d strobes but %0d valid pulses", strobeCount, validCount);
      failRun();
    end
  end

endmodule
